// ==== common/clock_pkg.sv ====
// ********************
// Timing constants for a 25 MHz clk_cpu and the single 640x480 mode
// ********************
`default_nettype none

package clock_pkg;

    localparam int CLK_HZ        = 25_000_000;
    localparam int CYCLES_PER_MS = CLK_HZ / 1000;
    localparam int PRESCALE_W    = $clog2(CYCLES_PER_MS);
    localparam logic [PRESCALE_W-1:0] MS_LAST = PRESCALE_W'(CYCLES_PER_MS - 1);

    localparam int RXQ_DEPTH = 16; // must stay 2**RXQ_AW
    localparam int RXQ_AW    = 4;

    localparam int H_RES = 640;
    localparam int V_RES = 480;

endpackage

`default_nettype wire

// ==== common/io_map_pkg.sv ====
// ********************
// I/O register map of the bus slave. Only the region code and the
// word index of an address are decoded, byte offset is ignored
// ********************
`default_nettype none

package io_map_pkg;

    localparam int DATA_W    = 32; // bus word
    localparam int REG_IDX_W = 4;  // word index within the I/O region
    localparam int LED_W     = 8;
    localparam int BYTE_W    = 8;

    localparam logic [3:0] IO_REGION = 4'hE; // top nibble of any I/O address

    // register indices
    localparam logic [REG_IDX_W-1:0] REG_MS        = 4'd0;
    localparam logic [REG_IDX_W-1:0] REG_LED       = 4'd1;
    localparam logic [REG_IDX_W-1:0] REG_UART_DATA = 4'd2;
    localparam logic [REG_IDX_W-1:0] REG_UART_STAT = 4'd3;
    localparam logic [REG_IDX_W-1:0] REG_CMD       = 4'd8;
    localparam logic [REG_IDX_W-1:0] REG_RES       = 4'd9;

    // Bus address, seen either as a whole word or split into fields.
    // The unused bits between region and index may hold anything
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [3:0]           region;
            logic [21:0]          unused;
            logic [REG_IDX_W-1:0] idx;
            logic [1:0]           offset; // byte lane, not decoded
        } f;
    } io_addr_u;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build io_tb with Verilator, run it and decide pass or fail from the log.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Mdir build --top-module io_tb -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./build/Vio_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
exit 1

// ==== src.f ====
common/io_map_pkg.sv
common/clock_pkg.sv
src/io_decode.sv
src/io_execute/rx_byte_queue.sv
src/io_execute/io_execute.sv
src/io_result.sv
src/io_top.sv
test/io_checker.sv
test/io_tb.sv

// ==== src/io_decode.sv ====
// ********************
// Addresses outside region 0xE are ignored without any response.
// Writes to registers 0, 3 and 9 have no effect
// ********************
`timescale 1ns/1ps
`default_nettype none

module io_decode (
    input  wire logic                              clk_cpu,
    input  wire logic                              rst_n,
    input  wire logic                              bus_sel_i,
    input  wire logic                              bus_we_i,
    input  wire logic [io_map_pkg::DATA_W-1:0]     bus_addr_i,
    input  wire logic [io_map_pkg::DATA_W-1:0]     bus_wdata_i,
    output      logic                              led_wr_o,
    output      logic                              tx_wr_o,
    output      logic                              cmd_wr_o,
    output      logic                              rx_pop_o,
    output      logic                              rd_en_o,
    output      logic [io_map_pkg::REG_IDX_W-1:0]  rd_idx_o,
    output      logic [io_map_pkg::DATA_W-1:0]     wdata_o
);

    io_map_pkg::io_addr_u addr;
    logic                 io_wr;
    logic                 io_rd;

    assign addr.raw = bus_addr_i;
    assign io_wr    = bus_sel_i && bus_we_i && (addr.f.region == io_map_pkg::IO_REGION);
    assign io_rd    = bus_sel_i && !bus_we_i && (addr.f.region == io_map_pkg::IO_REGION);

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_wr_o <= 1'b0;
            tx_wr_o  <= 1'b0;
            cmd_wr_o <= 1'b0;
            rx_pop_o <= 1'b0;
            rd_en_o  <= 1'b0;
        end else begin
            led_wr_o <= io_wr && (addr.f.idx == io_map_pkg::REG_LED);
            tx_wr_o  <= io_wr && (addr.f.idx == io_map_pkg::REG_UART_DATA); // transmit start
            cmd_wr_o <= io_wr && (addr.f.idx == io_map_pkg::REG_CMD);
            rx_pop_o <= io_rd && (addr.f.idx == io_map_pkg::REG_UART_DATA); // read consumes byte
            rd_en_o  <= io_rd;
        end
    end

    always_ff @(posedge clk_cpu) begin
        rd_idx_o <= addr.f.idx;
        wdata_o  <= bus_wdata_i;
    end

    // one access per cycle, so the three write targets never collide downstream
    a_one_write: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        $onehot0({led_wr_o, tx_wr_o, cmd_wr_o}));

endmodule

`default_nettype wire

// ==== src/io_execute/io_execute.sv ====
// ********************
// Command writes are never refused, cmd_ready is only read back.
// Received bytes arriving while the queue is full are lost
// ********************
`timescale 1ns/1ps
`default_nettype none

module io_execute (
    input  wire logic                           clk_cpu,
    input  wire logic                           rst_n,
    input  wire logic                           led_wr_i,
    input  wire logic                           tx_wr_i,
    input  wire logic                           cmd_wr_i,
    input  wire logic                           rx_pop_i,
    input  wire logic [io_map_pkg::DATA_W-1:0]  wdata_i,
    input  wire logic                           rx_valid_i,
    input  wire logic [io_map_pkg::BYTE_W-1:0]  rx_byte_i,
    output      logic [io_map_pkg::LED_W-1:0]   led_o,
    output      logic                           tx_start_o,
    output      logic [io_map_pkg::BYTE_W-1:0]  tx_data_o,
    output      logic                           cmd_valid_o,
    output      logic [io_map_pkg::DATA_W-1:0]  cmd_data_o,
    output      logic [io_map_pkg::DATA_W-1:0]  ms_count_o,
    output      logic [io_map_pkg::BYTE_W-1:0]  rx_head_o,
    output      logic                           rx_ready_o
);

    logic [clock_pkg::PRESCALE_W-1:0] prescale;
    logic                             q_empty;
    logic                             q_full;
    logic                             q_push;
    logic                             q_pop;

    assign q_push     = rx_valid_i && !q_full;  // overflow drops the byte
    assign q_pop      = rx_pop_i && !q_empty;   // empty read pops nothing
    assign rx_ready_o = !q_empty;

    rx_byte_queue rx_byte_queue_i (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .push_i      (q_push),
        .push_byte_i (rx_byte_i),
        .pop_i       (q_pop),
        .head_o      (rx_head_o),
        .empty_o     (q_empty),
        .full_o      (q_full)
    );

    // millisecond tick, first one CYCLES_PER_MS cycles after reset
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            prescale   <= '0;
            ms_count_o <= '0;
        end else if (prescale == clock_pkg::MS_LAST) begin
            prescale   <= '0;
            ms_count_o <= ms_count_o + 32'd1;
        end else begin
            prescale   <= prescale + 1'b1;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_o       <= '0;
            tx_start_o  <= 1'b0;
            cmd_valid_o <= 1'b0;
        end else begin
            tx_start_o  <= tx_wr_i;   // single-cycle strobes
            cmd_valid_o <= cmd_wr_i;
            if (led_wr_i) begin
                led_o <= wdata_i[io_map_pkg::LED_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (tx_wr_i) begin
            tx_data_o <= wdata_i[io_map_pkg::BYTE_W-1:0]; // low byte only
        end
        if (cmd_wr_i) begin
            cmd_data_o <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/io_execute/rx_byte_queue.sv ====
// ********************
// Caller must not push when full or pop when empty.
// Head byte is only meaningful while not empty
// ********************
`timescale 1ns/1ps
`default_nettype none

module rx_byte_queue (
    input  wire logic                           clk_cpu,
    input  wire logic                           rst_n,
    input  wire logic                           push_i,
    input  wire logic [io_map_pkg::BYTE_W-1:0]  push_byte_i,
    input  wire logic                           pop_i,
    output      logic [io_map_pkg::BYTE_W-1:0]  head_o,
    output      logic                           empty_o,
    output      logic                           full_o
);

    logic [io_map_pkg::BYTE_W-1:0] mem [clock_pkg::RXQ_DEPTH];
    logic [clock_pkg::RXQ_AW-1:0]  wr_ptr;
    logic [clock_pkg::RXQ_AW-1:0]  rd_ptr;
    logic [clock_pkg::RXQ_AW:0]    count; // one extra bit for the full state

    assign head_o  = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign full_o  = count[clock_pkg::RXQ_AW]; // depth is a power of two

    always_ff @(posedge clk_cpu) begin
        if (push_i) begin
            mem[wr_ptr] <= push_byte_i;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1; // pointers wrap naturally
            if (pop_i)  rd_ptr <= rd_ptr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== src/io_result.sv ====
// ********************
// Read data is sampled the cycle after the access, so a write one
// cycle earlier is already visible. Unmapped indices read zero
// ********************
`timescale 1ns/1ps
`default_nettype none

module io_result (
    input  wire logic                              clk_cpu,
    input  wire logic                              rst_n,
    input  wire logic                              rd_en_i,
    input  wire logic [io_map_pkg::REG_IDX_W-1:0]  rd_idx_i,
    input  wire logic [io_map_pkg::DATA_W-1:0]     ms_count_i,
    input  wire logic [io_map_pkg::LED_W-1:0]      led_i,
    input  wire logic [io_map_pkg::BYTE_W-1:0]     rx_head_i,
    input  wire logic                              rx_ready_i,
    input  wire logic                              tx_ready_i,
    input  wire logic                              cmd_ready_i,
    output      logic                              rd_valid_o,
    output      logic [io_map_pkg::DATA_W-1:0]     rd_data_o
);

    logic [io_map_pkg::DATA_W-1:0] rd_word;

    always_comb begin
        case (rd_idx_i)
            io_map_pkg::REG_MS:        rd_word = ms_count_i;
            io_map_pkg::REG_LED:       rd_word = {24'd0, led_i};
            io_map_pkg::REG_UART_DATA: rd_word = rx_ready_i ? {24'd0, rx_head_i} : '0;
            io_map_pkg::REG_UART_STAT: rd_word = {30'd0, tx_ready_i, rx_ready_i};
            io_map_pkg::REG_CMD:       rd_word = {31'd0, cmd_ready_i};
            io_map_pkg::REG_RES:       rd_word = {16'(clock_pkg::H_RES), 16'(clock_pkg::V_RES)};
            default:                   rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (rd_en_i) begin
            rd_data_o <= rd_word; // held between reads
        end
    end

    a_valid_latency: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        rd_valid_o == $past(rd_en_i));

endmodule

`default_nettype wire

// ==== src/io_top.sv ====
// ********************
// No back-pressure: a bus access may arrive every cycle.
// Reads answer two cycles after the strobe
// ********************
`timescale 1ns/1ps
`default_nettype none

module io_top (
    input  wire logic                           clk_cpu,
    input  wire logic                           rst_n,
    input  wire logic                           bus_sel_i,
    input  wire logic                           bus_we_i,
    input  wire logic [io_map_pkg::DATA_W-1:0]  bus_addr_i,
    input  wire logic [io_map_pkg::DATA_W-1:0]  bus_wdata_i,
    input  wire logic                           rx_valid_i,
    input  wire logic [io_map_pkg::BYTE_W-1:0]  rx_byte_i,
    input  wire logic                           tx_ready_i,
    input  wire logic                           cmd_ready_i,
    output      logic                           rd_valid_o,
    output      logic [io_map_pkg::DATA_W-1:0]  rd_data_o,
    output      logic [io_map_pkg::LED_W-1:0]   led_o,
    output      logic                           tx_start_o,
    output      logic [io_map_pkg::BYTE_W-1:0]  tx_data_o,
    output      logic                           cmd_valid_o,
    output      logic [io_map_pkg::DATA_W-1:0]  cmd_data_o
);

    logic                             led_wr;
    logic                             tx_wr;
    logic                             cmd_wr;
    logic                             rx_pop;
    logic                             rd_en;
    logic [io_map_pkg::REG_IDX_W-1:0] rd_idx;
    logic [io_map_pkg::DATA_W-1:0]    wdata;
    logic [io_map_pkg::DATA_W-1:0]    ms_count;
    logic [io_map_pkg::BYTE_W-1:0]    rx_head;
    logic                             rx_ready;

    io_decode io_decode_i (
        .clk_cpu (clk_cpu),     .rst_n       (rst_n),
        .bus_sel_i (bus_sel_i), .bus_we_i    (bus_we_i),
        .bus_addr_i (bus_addr_i), .bus_wdata_i (bus_wdata_i),
        .led_wr_o (led_wr),     .tx_wr_o     (tx_wr),
        .cmd_wr_o (cmd_wr),     .rx_pop_o    (rx_pop),
        .rd_en_o  (rd_en),      .rd_idx_o    (rd_idx),
        .wdata_o  (wdata)
    );

    io_execute io_execute_i (
        .clk_cpu (clk_cpu),     .rst_n       (rst_n),
        .led_wr_i (led_wr),     .tx_wr_i     (tx_wr),
        .cmd_wr_i (cmd_wr),     .rx_pop_i    (rx_pop),
        .wdata_i  (wdata),      .rx_valid_i  (rx_valid_i),
        .rx_byte_i (rx_byte_i), .led_o       (led_o),
        .tx_start_o (tx_start_o), .tx_data_o (tx_data_o),
        .cmd_valid_o (cmd_valid_o), .cmd_data_o (cmd_data_o),
        .ms_count_o (ms_count), .rx_head_o   (rx_head),
        .rx_ready_o (rx_ready)
    );

    io_result io_result_i (
        .clk_cpu (clk_cpu),     .rst_n       (rst_n),
        .rd_en_i (rd_en),       .rd_idx_i    (rd_idx),
        .ms_count_i (ms_count), .led_i       (led_o),
        .rx_head_i (rx_head),   .rx_ready_i  (rx_ready),
        .tx_ready_i (tx_ready_i), .cmd_ready_i (cmd_ready_i),
        .rd_valid_o (rd_valid_o), .rd_data_o (rd_data_o)
    );

endmodule

`default_nettype wire

// ==== test/io_cases.txt ====
// columns in hex: op, address or count, data, expected value
// op 1 write, 2 read, 3 receive, 4 levels {tx_ready,cmd_ready}, 5 idle, 6 ms read, 8 pop run
04 00000000 00000000 00000000
01 e0000004 000000a5 000000a5
02 e0000004 00000000 000000a5
02 e0000024 00000000 028001e0
11 e0000004 0000005a 0000005a
02 e0000004 00000000 0000005a
01 d0000004 000000ff 00000000
02 d0000024 00000000 00000000
02 e0000004 00000000 0000005a
02 e0000014 00000000 00000000
03 00000003 00000041 00000000
02 e000000c 00000000 00000001
08 00000003 00000000 00000041
02 e000000c 00000000 00000000
02 e0000008 00000000 00000000
03 00000012 00000060 00000000
08 00000010 00000000 00000060
02 e0000008 00000000 00000000
04 00000000 00000002 00000000
02 e000000c 00000000 00000002
01 e0000008 123456c3 000000c3
01 e0000020 cafe0001 cafe0001
02 e0000020 00000000 00000000
04 00000000 00000001 00000000
02 e0000020 00000000 00000001
02 e000000c 00000000 00000000
05 00007530 00000000 00000000
06 e0000000 00000000 00000000
05 000061a8 00000000 00000000
06 e0000000 00000000 00000000
00 00000000 00000000 00000000

// ==== test/io_checker.sv ====
// ********************
// Expected outputs come from the cases file. The millisecond value
// is derived here by counting clk_cpu cycles after reset release
// ********************
`timescale 1ns/1ps
`default_nettype none

module io_checker (
    input  wire logic        clk_cpu,
    input  wire logic        rst_n,
    input  wire logic        bus_sel_i,
    input  wire logic        bus_we_i,
    input  wire logic [31:0] bus_addr_i,
    input  wire logic        rd_valid_i,
    input  wire logic [31:0] rd_data_i,
    input  wire logic [7:0]  led_i,
    input  wire logic        tx_start_i,
    input  wire logic [7:0]  tx_data_i,
    input  wire logic        cmd_valid_i,
    input  wire logic [31:0] cmd_data_i,
    output      int          mismatch_cnt_o,
    output      int          other_cnt_o,
    output      int          pending_o
);

    localparam int MAX_CASES = 64;

    logic [31:0] cases [4*MAX_CASES];
    logic [31:0] exp_rd [$];
    bit          rd_is_ms [$];  // entry is a millisecond read
    logic [31:0] ms_exp [$];
    logic [7:0]  exp_led [$];
    logic [7:0]  exp_tx [$];
    logic [31:0] exp_cmd [$];
    int          strobe_cyc [$];
    int          cyc = 0;
    int          run_cycles = 0;
    int          mismatches = 0;
    int          others = 0;
    int          pending = 0;
    bit          loaded = 1'b0;
    logic [7:0]  led_prev;

    assign mismatch_cnt_o = mismatches;
    assign other_cnt_o    = others;
    assign pending_o      = pending;

    task automatic load_expectations();
        io_map_pkg::io_addr_u addr;
        logic [31:0]          op;
        logic [31:0]          want;
        $readmemh("test/io_cases.txt", cases);
        for (int n = 0; n < MAX_CASES; n++) begin
            op       = cases[4*n];
            addr.raw = cases[4*n+1];
            want     = cases[4*n+3];
            if ($isunknown(op) || op[3:0] == 4'h0) break;
            case (op[3:0])
                4'h1: if (addr.f.region == io_map_pkg::IO_REGION) begin
                    case (addr.f.idx)
                        io_map_pkg::REG_LED:       exp_led.push_back(want[7:0]);
                        io_map_pkg::REG_UART_DATA: exp_tx.push_back(want[7:0]);
                        io_map_pkg::REG_CMD:       exp_cmd.push_back(want);
                        default: ;                 // read-only or unmapped
                    endcase
                end
                4'h2: if (addr.f.region == io_map_pkg::IO_REGION) begin
                    exp_rd.push_back(want);
                    rd_is_ms.push_back(1'b0);
                end
                4'h6: begin
                    exp_rd.push_back('0);
                    rd_is_ms.push_back(1'b1);
                end
                4'h8: for (int i = 0; i < int'(addr.raw); i++) begin
                    exp_rd.push_back(32'(want + i)); // bytes come back in order
                    rd_is_ms.push_back(1'b0);
                end
                default: ;
            endcase
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            mismatches++;
            $display("MISMATCH %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic note_strobe();
        io_map_pkg::io_addr_u addr;
        addr.raw = bus_addr_i;
        if (bus_sel_i && !bus_we_i && addr.f.region == io_map_pkg::IO_REGION) begin
            strobe_cyc.push_back(cyc);
            // whole periods completed by the strobe edge
            if (addr.f.idx == io_map_pkg::REG_MS) begin
                ms_exp.push_back(32'(run_cycles / clock_pkg::CYCLES_PER_MS));
            end
        end
    endtask

    task automatic read_response();
        int          lat;
        logic [31:0] want;
        if (strobe_cyc.size() == 0 || exp_rd.size() == 0) begin
            others++;
            $display("read response arrived with no read pending");
        end else begin
            lat = cyc - strobe_cyc.pop_front(); // both taken at sampling edges
            if (lat != 2) begin
                others++;
                $display("read response came %0d cycles after its strobe, not 2", lat);
            end
            want = exp_rd.pop_front();
            if (rd_is_ms.pop_front()) want = ms_exp.pop_front();
            compare_word("rd_data_o", rd_data_i, want);
        end
    endtask

    always @(posedge clk_cpu) begin
        if (!loaded) begin
            load_expectations();
            loaded = 1'b1;
        end
        cyc = cyc + 1;
        if (!rst_n) begin
            run_cycles = 0;
            led_prev   = led_i;
        end else begin
            run_cycles = run_cycles + 1;
            note_strobe();
            if (rd_valid_i) read_response();
            if (led_i !== led_prev) begin
                if (exp_led.size() == 0) begin
                    others++;
                    $display("led_o changed without an LED write");
                end else begin
                    compare_word("led_o", 32'(led_i), 32'(exp_led.pop_front()));
                end
                led_prev = led_i;
            end
            if (tx_start_i) begin
                if (exp_tx.size() == 0) begin
                    others++;
                    $display("tx_start_o pulsed with no transmit write pending");
                end else begin
                    compare_word("tx_data_o", 32'(tx_data_i), 32'(exp_tx.pop_front()));
                end
            end
            if (cmd_valid_i) begin
                if (exp_cmd.size() == 0) begin
                    others++;
                    $display("cmd_valid_o pulsed with no command write pending");
                end else begin
                    compare_word("cmd_data_o", cmd_data_i, exp_cmd.pop_front());
                end
            end
        end
        pending = exp_rd.size() + exp_led.size() + exp_tx.size() + exp_cmd.size();
    end

endmodule

`default_nettype wire

// ==== test/io_tb.sv ====
// ********************
// Runs the access list in test/io_cases.txt against io_top.
// Must be started from the project root
// ********************
`timescale 1ns/1ps
`default_nettype none

module io_tb;

    localparam int MAX_CASES   = 64;
    localparam int RD_TIMEOUT  = 8;   // cycles allowed for a read response
    localparam int END_TIMEOUT = 64;

    logic        clk_cpu = 1'b0;
    logic        rst_n;
    logic        bus_sel_i;
    logic        bus_we_i;
    logic [31:0] bus_addr_i;
    logic [31:0] bus_wdata_i;
    logic        rx_valid_i;
    logic [7:0]  rx_byte_i;
    logic        tx_ready_i;
    logic        cmd_ready_i;
    logic        rd_valid_o;
    logic [31:0] rd_data_o;
    logic [7:0]  led_o;
    logic        tx_start_o;
    logic [7:0]  tx_data_o;
    logic        cmd_valid_o;
    logic [31:0] cmd_data_o;
    logic [31:0] cases [4*MAX_CASES];
    int          tb_errors = 0;
    int          mismatch_cnt;
    int          other_cnt;
    int          pending;

    always #20 clk_cpu = ~clk_cpu;

    io_top io_top_i (.*);

    io_checker io_checker_i (
        .clk_cpu        (clk_cpu),
        .rst_n          (rst_n),
        .bus_sel_i      (bus_sel_i),
        .bus_we_i       (bus_we_i),
        .bus_addr_i     (bus_addr_i),
        .rd_valid_i     (rd_valid_o),
        .rd_data_i      (rd_data_o),
        .led_i          (led_o),
        .tx_start_i     (tx_start_o),
        .tx_data_i      (tx_data_o),
        .cmd_valid_i    (cmd_valid_o),
        .cmd_data_i     (cmd_data_o),
        .mismatch_cnt_o (mismatch_cnt),
        .other_cnt_o    (other_cnt),
        .pending_o      (pending)
    );

    task automatic next_cycle();
        @(posedge clk_cpu);
        #2;                 // inputs change just after the edge
    endtask

    task automatic bus_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] data);
        bus_sel_i   = 1'b1;
        bus_we_i    = we;
        bus_addr_i  = addr;
        bus_wdata_i = data;
        next_cycle();
        bus_sel_i   = 1'b0;
    endtask

    task automatic wait_read();
        int n;
        n = 0;
        while (!rd_valid_o && n < RD_TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!rd_valid_o) begin
            tb_errors++;
            $display("no read response within %0d cycles", RD_TIMEOUT);
        end
    endtask

    task automatic receive_bytes(input logic [31:0] count, input logic [31:0] first);
        for (int i = 0; i < int'(count); i++) begin
            rx_valid_i = 1'b1;
            rx_byte_i  = 8'(first + i);
            next_cycle();
        end
        rx_valid_i = 1'b0;
    endtask

    task automatic run_case(input logic [31:0] op, input logic [31:0] arg,
                            input logic [31:0] dat);
        io_map_pkg::io_addr_u addr;
        io_map_pkg::io_addr_u q_addr;
        addr.raw        = arg;
        q_addr.raw      = '0;
        q_addr.f.region = io_map_pkg::IO_REGION;
        q_addr.f.idx    = io_map_pkg::REG_UART_DATA;
        case (op[3:0])
            4'h1: bus_access(1'b1, arg, dat);
            4'h2: begin
                bus_access(1'b0, arg, '0);
                if (addr.f.region == io_map_pkg::IO_REGION) wait_read(); // else no answer
            end
            4'h3: receive_bytes(arg, dat);
            4'h4: begin
                tx_ready_i  = dat[1];
                cmd_ready_i = dat[0];
            end
            4'h5: repeat (arg) next_cycle();
            4'h6: begin
                bus_access(1'b0, arg, '0);
                wait_read();
            end
            4'h8: for (int i = 0; i < int'(arg); i++) begin
                bus_access(1'b0, q_addr.raw, '0);
                wait_read();
            end
            default: begin
                tb_errors++;
                $display("unknown operation %h in the cases file", op);
            end
        endcase
    endtask

    initial begin
        logic [31:0] op;
        int          gap;
        int          n_run;
        int          waited;
        rst_n       = 1'b0;
        bus_sel_i   = 1'b0;
        bus_we_i    = 1'b0;
        bus_addr_i  = '0;
        bus_wdata_i = '0;
        rx_valid_i  = 1'b0;
        rx_byte_i   = '0;
        tx_ready_i  = 1'b0;
        cmd_ready_i = 1'b0;
        n_run       = 0;
        gap         = $urandom(32'h5d96); // one seed for the whole run
        $readmemh("test/io_cases.txt", cases);
        repeat (4) @(posedge clk_cpu);
        #2;
        rst_n = 1'b1;
        for (int n = 0; n < MAX_CASES; n++) begin
            op = cases[4*n];
            if ($isunknown(op) || op[3:0] == 4'h0) break;
            run_case(op, cases[4*n+1], cases[4*n+2]);
            n_run++;
            if (!op[4]) begin
                gap = $urandom % 4;
                repeat (gap) next_cycle();
            end
        end
        if (n_run == 0) begin
            tb_errors++;
            $display("no cases were read from test/io_cases.txt");
        end
        waited = 0;
        while (pending != 0 && waited < END_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (pending != 0) begin
            tb_errors++;
            $display("%0d expected outputs never arrived", pending);
        end
        $display("errors: testbench %0d, mismatches %0d, other %0d",
                 tb_errors, mismatch_cnt, other_cnt);
        if (tb_errors == 0 && mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
